//--- src/id_pkg.sv
// Shared types and encodings of the RV32I instruction decode stage
// Opcodes, ALU operations, operand selectors and the ID/EX state
package id_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data word, address or PC
  typedef logic [31:0] xlen_t;
  // Raw instruction word
  typedef logic [31:0] instr_t;
  // Register file index
  typedef logic [4:0]  reg_addr_t;

  // Link address increment, no compressed instructions
  localparam xlen_t instr_incr = 32'd4;

  ////////////////////
  // Opcodes
  ////////////////////

  typedef enum logic [6:0] {
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_BRANCH = 7'h63,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33
  } opcode_e;

  ////////////////////
  // ALU control
  ////////////////////

  typedef enum logic [4:0] {
    // Arithmetic and logic
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic {
    OP_A_REG_A,
    OP_A_CURRPC
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate kind driven onto operand B
  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // Memory access width of loads and stores
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  // ID/EX state
  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

endpackage

//--- src/id_decoder.sv
// RV32I instruction decoder
// Turns the instruction word into ALU, operand, register and memory controls
`timescale 1ns/100ps

module id_decoder #(
  parameter bit rv32e = 1'b0
) (
  input  id_pkg::instr_t     instr_rdata_i,
  input  logic               instr_first_cycle_i,

  output logic               illegal_insn_o,

  // Register file
  output id_pkg::reg_addr_t  rf_raddr_a_o,
  output id_pkg::reg_addr_t  rf_raddr_b_o,
  output id_pkg::reg_addr_t  rf_waddr_o,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,
  output logic               rf_we_o,

  // ALU
  output id_pkg::alu_op_e    alu_operator_o,
  output id_pkg::op_a_sel_e  alu_op_a_sel_o,
  output id_pkg::op_b_sel_e  alu_op_b_sel_o,
  output id_pkg::imm_b_sel_e imm_b_sel_o,

  // Load/store unit
  output logic               lsu_req_o,
  output logic               lsu_we_o,
  output id_pkg::lsu_type_e  lsu_type_o,
  output logic               lsu_sign_ext_o,

  // Control flow
  output logic               branch_in_dec_o,
  output logic               jump_in_dec_o
);

  import id_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal_dec;
  logic       illegal_reg;
  logic       lui_insn;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  ////////////////////
  // Register fields
  ////////////////////

  // LUI reads x0 so operand A is zero
  assign rf_raddr_a_o = lui_insn ? '0 : instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  // Unsigned loads have funct3[2] set
  assign lsu_sign_ext_o = ~funct3[2];

  // funct3[1:0] counts up from byte to word
  always_comb begin
    case (funct3[1:0])
      2'b00:   lsu_type_o = LSU_BYTE;
      2'b01:   lsu_type_o = LSU_HALF;
      default: lsu_type_o = LSU_WORD;
    endcase
  end

  ////////////////////
  // Main decode
  ////////////////////

  always_comb begin
    illegal_dec     = 1'b0;
    lui_insn        = 1'b0;
    rf_ren_a_o      = 1'b0;
    rf_ren_b_o      = 1'b0;
    rf_we_o         = 1'b0;
    alu_operator_o  = ALU_ADD;
    alu_op_a_sel_o  = OP_A_REG_A;
    alu_op_b_sel_o  = OP_B_IMM;
    imm_b_sel_o     = IMM_B_I;
    lsu_req_o       = 1'b0;
    lsu_we_o        = 1'b0;
    branch_in_dec_o = 1'b0;
    jump_in_dec_o   = 1'b0;

    unique case (opcode)
      OPC_LUI: begin
        lui_insn    = 1'b1;
        rf_ren_a_o  = 1'b1;
        rf_we_o     = 1'b1;
        imm_b_sel_o = IMM_B_U;
      end

      OPC_AUIPC: begin
        rf_we_o        = 1'b1;
        alu_op_a_sel_o = OP_A_CURRPC;
        imm_b_sel_o    = IMM_B_U;
      end

      OPC_JAL: begin
        jump_in_dec_o  = 1'b1;
        rf_we_o        = 1'b1;
        alu_op_a_sel_o = OP_A_CURRPC;
        // Jump target first, link address PC + 4 afterwards
        imm_b_sel_o    = instr_first_cycle_i ? IMM_B_J : IMM_B_INCR_PC;
      end

      OPC_BRANCH: begin
        branch_in_dec_o = 1'b1;
        if (instr_first_cycle_i) begin
          // Compare rs1 against rs2
          rf_ren_a_o     = 1'b1;
          rf_ren_b_o     = 1'b1;
          alu_op_b_sel_o = OP_B_REG_B;
        end else begin
          // Taken, so compute target PC + imm
          alu_op_a_sel_o = OP_A_CURRPC;
          imm_b_sel_o    = IMM_B_B;
        end
        unique case (funct3)
          3'b000:  alu_operator_o = instr_first_cycle_i ? ALU_EQ  : ALU_ADD;
          3'b001:  alu_operator_o = instr_first_cycle_i ? ALU_NE  : ALU_ADD;
          3'b100:  alu_operator_o = instr_first_cycle_i ? ALU_LT  : ALU_ADD;
          3'b101:  alu_operator_o = instr_first_cycle_i ? ALU_GE  : ALU_ADD;
          3'b110:  alu_operator_o = instr_first_cycle_i ? ALU_LTU : ALU_ADD;
          3'b111:  alu_operator_o = instr_first_cycle_i ? ALU_GEU : ALU_ADD;
          default: illegal_dec    = 1'b1;
        endcase
      end

      OPC_LOAD: begin
        rf_ren_a_o = 1'b1;
        rf_we_o    = 1'b1;
        lsu_req_o  = 1'b1;
        // LB LH LW LBU LHU only
        if (funct3 == 3'b011 || funct3[2:1] == 2'b11) begin
          illegal_dec = 1'b1;
        end
      end

      OPC_STORE: begin
        rf_ren_a_o  = 1'b1;
        rf_ren_b_o  = 1'b1;
        lsu_req_o   = 1'b1;
        lsu_we_o    = 1'b1;
        imm_b_sel_o = IMM_B_S;
        if (funct3[2] || funct3 == 3'b011) begin
          illegal_dec = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        rf_ren_a_o = 1'b1;
        rf_we_o    = 1'b1;
        unique case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_dec    = (funct7 != 7'b000_0000);
          end
          default: begin
            // SRLI or SRAI, funct7 bit 5 picks arithmetic
            alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_dec    = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end

      OPC_OP: begin
        rf_ren_a_o     = 1'b1;
        rf_ren_b_o     = 1'b1;
        rf_we_o        = 1'b1;
        alu_op_b_sel_o = OP_B_REG_B;
        unique case ({funct7, funct3})
          10'b0000000_000: alu_operator_o = ALU_ADD;
          10'b0100000_000: alu_operator_o = ALU_SUB;
          10'b0000000_001: alu_operator_o = ALU_SLL;
          10'b0000000_010: alu_operator_o = ALU_SLT;
          10'b0000000_011: alu_operator_o = ALU_SLTU;
          10'b0000000_100: alu_operator_o = ALU_XOR;
          10'b0000000_101: alu_operator_o = ALU_SRL;
          10'b0100000_101: alu_operator_o = ALU_SRA;
          10'b0000000_110: alu_operator_o = ALU_OR;
          10'b0000000_111: alu_operator_o = ALU_AND;
          default:         illegal_dec    = 1'b1;
        endcase
      end

      default: begin
        illegal_dec = 1'b1;
      end
    endcase
  end

  // RV32E has only x0 to x15
  assign illegal_reg = rv32e & ((rf_ren_a_o & rf_raddr_a_o[4]) |
                                (rf_ren_b_o & rf_raddr_b_o[4]) |
                                (rf_we_o    & rf_waddr_o[4]));

  assign illegal_insn_o = illegal_dec | illegal_reg;

endmodule

//--- src/id_operand_mux.sv
// ALU operand selection
// Builds sign-extended immediates and picks operand A, operand B and store data
`timescale 1ns/100ps

module id_operand_mux (
  input  id_pkg::instr_t     instr_rdata_i,
  input  id_pkg::xlen_t      pc_id_i,
  input  id_pkg::xlen_t      rf_rdata_a_i,
  input  id_pkg::xlen_t      rf_rdata_b_i,
  input  id_pkg::op_a_sel_e  alu_op_a_sel_i,
  input  id_pkg::op_b_sel_e  alu_op_b_sel_i,
  input  id_pkg::imm_b_sel_e imm_b_sel_i,

  output id_pkg::xlen_t      alu_operand_a_o,
  output id_pkg::xlen_t      alu_operand_b_o,
  output id_pkg::xlen_t      lsu_wdata_o
);

  import id_pkg::*;

  xlen_t imm_i_type;
  xlen_t imm_s_type;
  xlen_t imm_b_type;
  xlen_t imm_u_type;
  xlen_t imm_j_type;
  xlen_t imm_b;

  ////////////////////
  // Immediates
  ////////////////////

  // Bit 31 of the instruction is the sign of every format
  assign imm_i_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_type = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b_type = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                       instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_type = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                       instr_rdata_i[30:21], 1'b0};

  always_comb begin
    unique case (imm_b_sel_i)
      IMM_B_I:       imm_b = imm_i_type;
      IMM_B_S:       imm_b = imm_s_type;
      IMM_B_B:       imm_b = imm_b_type;
      IMM_B_U:       imm_b = imm_u_type;
      IMM_B_J:       imm_b = imm_j_type;
      IMM_B_INCR_PC: imm_b = instr_incr;
      default:       imm_b = instr_incr;
    endcase
  end

  ////////////////////
  // Operands
  ////////////////////

  assign alu_operand_a_o = (alu_op_a_sel_i == OP_A_CURRPC) ? pc_id_i : rf_rdata_a_i;
  assign alu_operand_b_o = (alu_op_b_sel_i == OP_B_IMM)    ? imm_b   : rf_rdata_b_i;

  // No forwarding, store data comes straight from the register file
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

//--- src/id_ex_fsm.sv
// ID/EX state machine
// Stalls loads, stores, jumps and taken branches and signals instruction done
`timescale 1ns/100ps

module id_ex_fsm (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic instr_valid_i,
  input  logic illegal_insn_i,
  input  logic lsu_req_dec_i,
  input  logic branch_in_dec_i,
  input  logic jump_in_dec_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,

  output logic instr_first_cycle_o,
  output logic instr_executing_o,
  output logic instr_done_o,
  output logic pc_set_o,
  output logic perf_branch_o
);

  import id_pkg::*;

  id_fsm_e id_fsm_q, id_fsm_d;

  logic stall_mem;
  logic stall_branch;
  logic stall_jump;
  logic stall_id;
  logic multicycle_done;
  logic branch_set_d, branch_set_q;
  logic jump_set;
  logic set_done_d, set_done_q;

  // Illegal instructions never execute, they finish at once
  assign instr_executing_o   = instr_valid_i & ~illegal_insn_i;
  assign instr_first_cycle_o = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Only memory accesses wait on an external event
  assign multicycle_done = lsu_req_dec_i ? lsu_resp_valid_i : 1'b1;

  // First cycle of a load/store always stalls, then wait for the response
  assign stall_mem = instr_executing_o & lsu_req_dec_i &
                     (~lsu_resp_valid_i | instr_first_cycle_o);

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (instr_executing_o) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  always_comb begin
    id_fsm_d      = id_fsm_q;
    stall_branch  = 1'b0;
    stall_jump    = 1'b0;
    branch_set_d  = 1'b0;
    jump_set      = 1'b0;
    perf_branch_o = 1'b0;

    if (instr_executing_o) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_req_dec_i) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_in_dec_i) begin
            // Taken branch needs a second cycle for the target
            id_fsm_d      = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch  = branch_decision_i;
            branch_set_d  = branch_decision_i;
            perf_branch_o = 1'b1;
          end else if (jump_in_dec_i) begin
            // Redirect now, write the link address next cycle
            id_fsm_d   = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
          end
        end

        MULTI_CYCLE: begin
          // Branches and jumps finish here at once, memory waits in stall_mem
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end
        end

        default: begin
          id_fsm_d = FIRST_CYCLE;
        end
      endcase
    end
  end

  assign stall_id     = stall_mem | stall_branch | stall_jump;
  assign instr_done_o = instr_valid_i & ~stall_id;

  ////////////////////
  // PC set
  ////////////////////

  // Branch decision is used one cycle later when the target is on the ALU
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
    end
  end

  // Remember a redirect until the instruction leaves ID
  assign set_done_d = (branch_set_q | jump_set | set_done_q) & ~instr_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_done_q <= 1'b0;
    end else begin
      set_done_q <= set_done_d;
    end
  end

  assign pc_set_o = instr_executing_o & (branch_set_q | jump_set) & ~set_done_q;

endmodule

//--- src/id_stage.sv
// Instruction decode stage of a small in-order RV32I core
// Decodes, selects operands and sequences multi-cycle instructions
`timescale 1ns/100ps

module id_stage #(
  parameter bit rv32e = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  // From IF
  input  logic               instr_valid_i,
  input  id_pkg::instr_t     instr_rdata_i,
  input  id_pkg::xlen_t      pc_id_i,
  output logic               id_in_ready_o,
  output logic               illegal_insn_o,

  // From EX and LSU
  input  logic               branch_decision_i,
  input  logic               lsu_resp_valid_i,

  // Register file reads
  output id_pkg::reg_addr_t  rf_raddr_a_o,
  output id_pkg::reg_addr_t  rf_raddr_b_o,
  input  id_pkg::xlen_t      rf_rdata_a_i,
  input  id_pkg::xlen_t      rf_rdata_b_i,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,

  // Register file write
  output id_pkg::reg_addr_t  rf_waddr_o,
  output logic               rf_we_o,

  // ALU
  output id_pkg::alu_op_e    alu_operator_o,
  output id_pkg::xlen_t      alu_operand_a_o,
  output id_pkg::xlen_t      alu_operand_b_o,

  // Load/store unit
  output logic               lsu_req_o,
  output logic               lsu_we_o,
  output id_pkg::lsu_type_e  lsu_type_o,
  output logic               lsu_sign_ext_o,
  output id_pkg::xlen_t      lsu_wdata_o,

  // To IF
  output logic               pc_set_o,
  output logic               instr_done_o,
  output logic               perf_branch_o
);

  import id_pkg::*;

  logic       illegal_dec;
  logic       rf_ren_a_dec, rf_ren_b_dec, rf_we_dec;
  logic       lsu_req_dec;
  logic       branch_in_dec, jump_in_dec;
  logic       instr_first_cycle;
  logic       instr_executing;
  op_a_sel_e  alu_op_a_sel;
  op_b_sel_e  alu_op_b_sel;
  imm_b_sel_e imm_b_sel;

  ////////////////////
  // Decoder
  ////////////////////

  id_decoder #(
    .rv32e (rv32e)
  ) decoder_i (
    .instr_rdata_i       (instr_rdata_i),
    .instr_first_cycle_i (instr_first_cycle),
    .illegal_insn_o      (illegal_dec),
    .rf_raddr_a_o        (rf_raddr_a_o),
    .rf_raddr_b_o        (rf_raddr_b_o),
    .rf_waddr_o          (rf_waddr_o),
    .rf_ren_a_o          (rf_ren_a_dec),
    .rf_ren_b_o          (rf_ren_b_dec),
    .rf_we_o             (rf_we_dec),
    .alu_operator_o      (alu_operator_o),
    .alu_op_a_sel_o      (alu_op_a_sel),
    .alu_op_b_sel_o      (alu_op_b_sel),
    .imm_b_sel_o         (imm_b_sel),
    .lsu_req_o           (lsu_req_dec),
    .lsu_we_o            (lsu_we_o),
    .lsu_type_o          (lsu_type_o),
    .lsu_sign_ext_o      (lsu_sign_ext_o),
    .branch_in_dec_o     (branch_in_dec),
    .jump_in_dec_o       (jump_in_dec)
  );

  ////////////////////
  // Operands
  ////////////////////

  id_operand_mux operand_mux_i (
    .instr_rdata_i   (instr_rdata_i),
    .pc_id_i         (pc_id_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .alu_op_a_sel_i  (alu_op_a_sel),
    .alu_op_b_sel_i  (alu_op_b_sel),
    .imm_b_sel_i     (imm_b_sel),
    .alu_operand_a_o (alu_operand_a_o),
    .alu_operand_b_o (alu_operand_b_o),
    .lsu_wdata_o     (lsu_wdata_o)
  );

  ////////////////////
  // ID/EX FSM
  ////////////////////

  id_ex_fsm ex_fsm_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .illegal_insn_i      (illegal_insn_o),
    .lsu_req_dec_i       (lsu_req_dec),
    .branch_in_dec_i     (branch_in_dec),
    .jump_in_dec_i       (jump_in_dec),
    .branch_decision_i   (branch_decision_i),
    .lsu_resp_valid_i    (lsu_resp_valid_i),
    .instr_first_cycle_o (instr_first_cycle),
    .instr_executing_o   (instr_executing),
    .instr_done_o        (instr_done_o),
    .pc_set_o            (pc_set_o),
    .perf_branch_o       (perf_branch_o)
  );

  ////////////////////
  // Output gating
  ////////////////////

  assign illegal_insn_o = instr_valid_i & illegal_dec;

  // Reads only for valid, legal instructions
  assign rf_ren_a_o = instr_valid_i & ~illegal_insn_o & rf_ren_a_dec;
  assign rf_ren_b_o = instr_valid_i & ~illegal_insn_o & rf_ren_b_dec;

  // One request per load/store, issued in its first cycle
  assign lsu_req_o = instr_executing & instr_first_cycle & lsu_req_dec;

  // Write back when the result is final
  assign rf_we_o = rf_we_dec & instr_done_o & ~illegal_insn_o;

  // Accept the next instruction when this one completes or ID is empty
  assign id_in_ready_o = instr_done_o | ~instr_valid_i;

endmodule

//--- verif/id_stage_chk.sv
// Assertion checker for the instruction decode stage
// Watches PC redirects, memory requests and completion of illegal instructions
`timescale 1ns/100ps

module id_stage_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic pc_set_i,
  input logic lsu_req_i,
  input logic instr_done_i,
  input logic illegal_insn_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  // Redirect is a single-cycle strobe
  pc_set_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else begin
      fail_cnt++;
      $error("pc_set_o stayed high for two cycles");
    end

  // Back-to-back requests only across an instruction boundary
  lsu_req_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu_req_i && $past(lsu_req_i)) |-> $past(instr_done_i))
    else begin
      fail_cnt++;
      $error("lsu_req_o repeated for the same instruction");
    end

  // Illegal instructions never stall
  illegal_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i |-> instr_done_i)
    else begin
      fail_cnt++;
      $error("illegal instruction not done in its cycle");
    end

endmodule

bind id_stage id_stage_chk chk_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .pc_set_i       (pc_set_o),
  .lsu_req_i      (lsu_req_o),
  .instr_done_i   (instr_done_o),
  .illegal_insn_i (illegal_insn_o)
);

//--- verif/tb_id_stage.sv
// Testbench for the instruction decode stage
// Runs instruction sequences through the DUT and checks against a reference decoder
`timescale 1ns/100ps

module tb_id_stage;

  import id_pkg::*;

  localparam bit rv32e          = 1'b1;
  localparam int timeout_cycles = 20;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       instr_valid_i;
  instr_t     instr_rdata_i;
  xlen_t      pc_id_i;
  logic       branch_decision_i;
  logic       lsu_resp_valid_i;
  xlen_t      rf_rdata_a_i;
  xlen_t      rf_rdata_b_i;
  logic       id_in_ready_o;
  logic       illegal_insn_o;
  reg_addr_t  rf_raddr_a_o;
  reg_addr_t  rf_raddr_b_o;
  reg_addr_t  rf_waddr_o;
  logic       rf_ren_a_o;
  logic       rf_ren_b_o;
  logic       rf_we_o;
  alu_op_e    alu_operator_o;
  xlen_t      alu_operand_a_o;
  xlen_t      alu_operand_b_o;
  logic       lsu_req_o;
  logic       lsu_we_o;
  lsu_type_e  lsu_type_o;
  logic       lsu_sign_ext_o;
  xlen_t      lsu_wdata_o;
  logic       pc_set_o;
  logic       instr_done_o;
  logic       perf_branch_o;

  integer     seed = 32'h02af_491b;
  int         err_cnt = 0;
  int         cyc_cnt = 0;
  string      cur_test = "reset";
  logic       cur_taken = 1'b0;
  int         cur_delay = 0;
  // Register file contents, x0 is hardwired to zero
  xlen_t      regs [32];

  id_stage #(.rv32e(rv32e)) id_stage_i (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////
  // Reference model
  ////////////////////

  // Expected decode of one instruction in its first or a later cycle
  function automatic void ref_decode(input instr_t instr, input xlen_t pc, input xlen_t rs1_v,
                                     input xlen_t rs2_v, input logic first,
                                     output alu_op_e op, output xlen_t opa, output xlen_t opb,
                                     output logic ren_a, output logic ren_b, output logic we,
                                     output logic ill);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_addr_t  rs1_idx;
    xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'h000};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    // LUI adds its immediate to x0
    rs1_idx = (opc == OPC_LUI) ? 5'd0 : instr[19:15];
    op    = ALU_ADD;
    opa   = rs1_v;
    opb   = imm_i;
    ren_a = 1'b0;
    ren_b = 1'b0;
    we    = 1'b0;
    ill   = 1'b0;
    case (opc)
      OPC_LUI: begin
        opb   = imm_u;
        ren_a = 1'b1;
        we    = 1'b1;
      end
      OPC_AUIPC: begin
        opa = pc;
        opb = imm_u;
        we  = 1'b1;
      end
      OPC_JAL: begin
        opa = pc;
        // Target first, then the link address
        opb = first ? imm_j : 32'd4;
        we  = 1'b1;
      end
      OPC_BRANCH: begin
        ill = (f3 == 3'b010 || f3 == 3'b011);
        if (first) begin
          ren_a = 1'b1;
          ren_b = 1'b1;
          opb   = rs2_v;
          case (f3)
            3'b000:  op = ALU_EQ;
            3'b001:  op = ALU_NE;
            3'b100:  op = ALU_LT;
            3'b101:  op = ALU_GE;
            3'b110:  op = ALU_LTU;
            default: op = ALU_GEU;
          endcase
        end else begin
          opa = pc;
          opb = imm_b;
        end
      end
      OPC_LOAD: begin
        ren_a = 1'b1;
        we    = 1'b1;
        ill   = (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111);
      end
      OPC_STORE: begin
        ren_a = 1'b1;
        ren_b = 1'b1;
        opb   = imm_s;
        ill   = (f3 > 3'b010);
      end
      OPC_OP_IMM: begin
        ren_a = 1'b1;
        we    = 1'b1;
        case (f3)
          3'b000: op = ALU_ADD;
          3'b010: op = ALU_SLT;
          3'b011: op = ALU_SLTU;
          3'b100: op = ALU_XOR;
          3'b110: op = ALU_OR;
          3'b111: op = ALU_AND;
          3'b001: begin
            op  = ALU_SLL;
            ill = (f7 != 7'h00);
          end
          default: begin
            op  = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
            ill = (f7 != 7'h00 && f7 != 7'h20);
          end
        endcase
      end
      OPC_OP: begin
        ren_a = 1'b1;
        ren_b = 1'b1;
        we    = 1'b1;
        opb   = rs2_v;
        case ({f7, f3})
          10'b0000000_000: op = ALU_ADD;
          10'b0100000_000: op = ALU_SUB;
          10'b0000000_001: op = ALU_SLL;
          10'b0000000_010: op = ALU_SLT;
          10'b0000000_011: op = ALU_SLTU;
          10'b0000000_100: op = ALU_XOR;
          10'b0000000_101: op = ALU_SRL;
          10'b0100000_101: op = ALU_SRA;
          10'b0000000_110: op = ALU_OR;
          10'b0000000_111: op = ALU_AND;
          default:         ill = 1'b1;
        endcase
      end
      default: ill = 1'b1;
    endcase
    // Only x0 to x15 exist in RV32E
    if (rv32e && ((ren_a && rs1_idx[4]) || (ren_b && instr[24]) || (we && instr[11]))) begin
      ill = 1'b1;
    end
    if (ill) begin
      ren_a = 1'b0;
      ren_b = 1'b0;
      we    = 1'b0;
    end
  endfunction

  // Access width of a load or store, LB/LBU 000, LH/LHU 001, LW 010
  function automatic lsu_type_e lsu_width(input logic [2:0] f3);
    if (f3[1]) begin
      return LSU_WORD;
    end else if (f3[0]) begin
      return LSU_HALF;
    end
    return LSU_BYTE;
  endfunction

  ////////////////////
  // Checking
  ////////////////////

  task automatic check_val(input string sig, input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      err_cnt++;
      $display("ERR %s %s: expected %h, actual %h", cur_test, sig, exp_v, act_v);
    end
  endtask

  // Compare all outputs in cycle cyc of the current instruction
  task automatic compare_outputs(input int cyc);
    alu_op_e    e_op;
    xlen_t      e_a, e_b;
    logic       e_ren_a, e_ren_b, e_we, e_ill;
    logic       is_mem, is_br, is_jal, e_done, e_pc_set;
    logic [6:0] opc;
    opc = instr_rdata_i[6:0];
    ref_decode(instr_rdata_i, pc_id_i, rf_rdata_a_i, rf_rdata_b_i, cyc == 1,
               e_op, e_a, e_b, e_ren_a, e_ren_b, e_we, e_ill);
    is_mem = !e_ill && (opc == OPC_LOAD || opc == OPC_STORE);
    is_br  = !e_ill && (opc == OPC_BRANCH);
    is_jal = !e_ill && (opc == OPC_JAL);
    // Memory waits for the response, taken branch and JAL take two cycles
    if (is_mem) begin
      e_done = (cyc == 1 + cur_delay);
    end else if ((is_br && cur_taken) || is_jal) begin
      e_done = (cyc == 2);
    end else begin
      e_done = (cyc == 1);
    end
    e_pc_set = (is_br && cur_taken && cyc == 2) || (is_jal && cyc == 1);
    check_val("illegal_insn_o", e_ill, illegal_insn_o);
    check_val("instr_done_o", e_done, instr_done_o);
    check_val("id_in_ready_o", e_done, id_in_ready_o);
    check_val("pc_set_o", e_pc_set, pc_set_o);
    // Every legal branch is counted once, in its first cycle
    check_val("perf_branch_o", is_br && cyc == 1, perf_branch_o);
    check_val("lsu_req_o", is_mem && cyc == 1, lsu_req_o);
    check_val("rf_ren_a_o", e_ren_a, rf_ren_a_o);
    check_val("rf_ren_b_o", e_ren_b, rf_ren_b_o);
    check_val("rf_we_o", e_we && e_done, rf_we_o);
    if (!e_ill) begin
      check_val("alu_operator_o", e_op, alu_operator_o);
      check_val("alu_operand_a_o", e_a, alu_operand_a_o);
      check_val("alu_operand_b_o", e_b, alu_operand_b_o);
      if (e_we) begin
        check_val("rf_waddr_o", instr_rdata_i[11:7], rf_waddr_o);
      end
      if (e_ren_a) begin
        check_val("rf_raddr_a_o", (opc == OPC_LUI) ? 5'd0 : instr_rdata_i[19:15], rf_raddr_a_o);
      end
      if (e_ren_b) begin
        check_val("rf_raddr_b_o", instr_rdata_i[24:20], rf_raddr_b_o);
      end
      if (is_mem) begin
        check_val("lsu_we_o", opc == OPC_STORE, lsu_we_o);
        check_val("lsu_type_o", lsu_width(instr_rdata_i[14:12]), lsu_type_o);
      end
      if (opc == OPC_LOAD) begin
        // LBU and LHU zero-extend
        check_val("lsu_sign_ext_o", !instr_rdata_i[14], lsu_sign_ext_o);
      end
      if (opc == OPC_STORE) begin
        check_val("lsu_wdata_o", rf_rdata_b_i, lsu_wdata_o);
      end
    end
  endtask

  // Outputs sampled half a cycle after the inputs change
  always @(negedge clk_i) begin
    if (!instr_valid_i) begin
      cyc_cnt = 0;
      check_val("pc_set_o", 1'b0, pc_set_o);
      check_val("lsu_req_o", 1'b0, lsu_req_o);
      check_val("rf_we_o", 1'b0, rf_we_o);
      check_val("instr_done_o", 1'b0, instr_done_o);
    end else begin
      cyc_cnt = cyc_cnt + 1;
      compare_outputs(cyc_cnt);
      if (instr_done_o) begin
        cyc_cnt = 0;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'($random(seed) & 15);
  endfunction

  function automatic instr_t fields(input logic [6:0] hi, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t lo, input logic [6:0] opc);
    return {hi, rs2, rs1, f3, lo, opc};
  endfunction

  // Present one instruction and hold it until the DUT reports done
  task automatic run_instr(input string name, input instr_t instr, input logic taken,
                           input int delay);
    int        n;
    logic      done_seen;
    reg_addr_t rs1_idx;
    rs1_idx   = (instr[6:0] == OPC_LUI) ? 5'd0 : instr[19:15];
    cur_test  = name;
    cur_taken = taken;
    cur_delay = delay;
    instr_valid_i     <= 1'b1;
    instr_rdata_i     <= instr;
    pc_id_i           <= $random(seed) & 32'hffff_fffc;
    rf_rdata_a_i      <= regs[rs1_idx];
    rf_rdata_b_i      <= regs[instr[24:20]];
    branch_decision_i <= taken;
    lsu_resp_valid_i  <= 1'b0;
    n         = 0;
    done_seen = 1'b0;
    while (!done_seen && n < timeout_cycles) begin
      @(negedge clk_i);
      n++;
      done_seen = instr_done_o;
      if (!done_seen) begin
        @(posedge clk_i);
        // Memory response lands in cycle 1 + delay
        lsu_resp_valid_i <= (n == delay);
      end
    end
    if (done_seen) begin
      @(posedge clk_i);
    end else begin
      $display("Timeout: %s not done after %0d cycles", name, timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  endtask

  initial begin
    instr_t     ins;
    logic [31:0] rnd;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    for (int i = 0; i < 32; i++) begin
      regs[i] = (i == 0) ? 32'h0 : $random(seed);
    end
    rst_ni            <= 1'b0;
    instr_valid_i     <= 1'b0;
    instr_rdata_i     <= '0;
    pc_id_i           <= '0;
    branch_decision_i <= 1'b0;
    lsu_resp_valid_i  <= 1'b0;
    rf_rdata_a_i      <= '0;
    rf_rdata_b_i      <= '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Register and immediate ALU operations
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      f3  = rnd[14:12];
      if (i % 2 == 0) begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && rnd[0]) ? 7'h20 : 7'h00;
        run_instr("op", fields(f7, rand_reg(), rand_reg(), f3, rand_reg(), OPC_OP), 1'b0, 0);
      end else begin
        imm = rnd[31:20];
        if (f3 == 3'b001) imm[11:5] = 7'h00;
        if (f3 == 3'b101) imm[11:5] = imm[10] ? 7'h20 : 7'h00;
        ins = fields(imm[11:5], imm[4:0], rand_reg(), f3, rand_reg(), OPC_OP_IMM);
        run_instr("op_imm", ins, 1'b0, 0);
      end
    end

    // Upper immediates
    for (int i = 0; i < 10; i++) begin
      rnd = $random(seed);
      run_instr("lui", {rnd[31:12], rand_reg(), OPC_LUI}, 1'b0, 0);
      rnd = $random(seed);
      run_instr("auipc", {rnd[31:12], rand_reg(), OPC_AUIPC}, 1'b0, 0);
    end

    // Loads and stores with a 1 to 5 cycle response delay
    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      f3  = {$random(seed)} % 3;
      if (i % 2 == 0) begin
        if (f3 != 3'b010 && rnd[0]) f3[2] = 1'b1;
        ins = fields(rnd[31:25], rnd[24:20], rand_reg(), f3, rand_reg(), OPC_LOAD);
        run_instr("load", ins, 1'b0, 1 + {$random(seed)} % 5);
      end else begin
        ins = fields(rnd[31:25], rand_reg(), rand_reg(), f3, rnd[11:7], OPC_STORE);
        run_instr("store", ins, 1'b0, 1 + {$random(seed)} % 5);
      end
    end

    // Branches with random decisions, then jumps
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      f3  = {$random(seed)} % 6;
      if (f3 >= 3'd2) f3 = f3 + 3'd2;
      ins = fields(rnd[31:25], rand_reg(), rand_reg(), f3, rnd[11:7], OPC_BRANCH);
      run_instr("branch", ins, rnd[0], 0);
    end
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      run_instr("jal", {rnd[31:12], rand_reg(), OPC_JAL}, 1'b0, 0);
    end

    // Illegal encodings and registers beyond x15
    rnd = $random(seed);
    run_instr("bad_opcode", {rnd[31:7], 7'h7f}, 1'b0, 0);
    run_instr("bad_opcode", {rnd[31:7], 7'h0b}, 1'b0, 0);
    run_instr("bad_funct", fields(7'h01, 5'd1, 5'd2, 3'b000, 5'd3, OPC_OP), 1'b0, 0);
    run_instr("bad_branch", fields(rnd[31:25], 5'd1, 5'd2, 3'b010, 5'd3, OPC_BRANCH), 1'b1, 0);
    run_instr("rv32e_rd", fields(7'h00, 5'd1, 5'd2, 3'b000, 5'd20, OPC_OP), 1'b0, 0);
    run_instr("rv32e_rs1", fields(rnd[31:25], rnd[24:20], 5'd17, 3'b010, 5'd3, OPC_LOAD),
              1'b0, 3);
    run_instr("rv32e_rs2", fields(7'h00, 5'd31, 5'd4, 3'b000, 5'd5, OPC_OP), 1'b0, 0);

    instr_valid_i    <= 1'b0;
    lsu_resp_valid_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    // Failures of the bound assertions count as well
    err_cnt += id_stage_i.chk_i.fail_cnt;
    $display("Checks finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sources.f
src/id_pkg.sv
src/id_decoder.sv
src/id_operand_mux.sv
src/id_ex_fsm.sv
src/id_stage.sv
verif/id_stage_chk.sv
verif/tb_id_stage.sv
